// ==== source/play_cfg_pkg.sv ====
package play_cfg_pkg;

    // Countdown step length in prog_clk cycles
    localparam int count_ticks = 60;

    // Judge strobe period and strobes per note step
    localparam int judge_ticks = 3;
    localparam int note_judges = 2;

    // Counter widths derived from the timing above
    localparam int tick_w = $clog2(count_ticks);
    localparam int step_w = $clog2(note_judges);

    // Chart memory geometry
    localparam int chart_len = 64;
    localparam int addr_w = 6;

    // Score accumulators
    localparam int score_w = 14;
    localparam int pts_max = 5;
    localparam int pts_auto = 4;
    localparam int pts_exact = 5;
    localparam int pts_late1 = 3;
    localparam int pts_late2 = 2;

    // Seven scale keys, C to B
    localparam int key_w = 7;

    // Arrow key codes
    localparam logic [1:0] arrow_left = 2'd1;
    localparam logic [1:0] arrow_right = 2'd2;

endpackage

// ==== source/play_types_pkg.sv ====
package play_types_pkg;

    // One chart note, keys is one-hot with bit 0 as C
    typedef struct packed {
        logic oct_down;
        logic oct_up;
        logic [play_cfg_pkg::key_w-1:0] keys;
    } note_t;

    // Raw player controls
    typedef struct packed {
        logic [1:0] arrow;
        logic [play_cfg_pkg::key_w-1:0] note_keys;
        logic oct_up;
        logic oct_down;
        logic [7:0] user_id;
        logic [7:0] chart_id;
    } user_in_t;

    // Eight characters, leftmost in the top byte
    typedef logic [7:0][7:0] seg_text_t;

    typedef logic [7:0] led_t;

    // Everything the play stage shows to the outside
    typedef struct packed {
        note_t notes;
        led_t led;
        seg_text_t seg;
        logic in_menu;
        logic started;
        logic finished;
    } play_out_t;

    // Record written when the player saves
    typedef struct packed {
        logic [7:0] user_id;
        logic [7:0] chart_id;
        logic [play_cfg_pkg::score_w-1:0] score;
        logic free_play;
    } save_rec_t;

endpackage

// ==== source/play_sequencer.sv ====
`timescale 1ns/1ps

module play_sequencer (
    input logic prog_clk,
    input logic rst,
    input logic [play_cfg_pkg::addr_w:0] note_cnt,
    output logic [play_cfg_pkg::addr_w-1:0] note_addr,
    output logic started,
    output logic finished,
    output logic playing,
    output logic judge_stb,
    output logic note_stb
);

    // Shared by the countdown and, once started, the judge prescaler
    logic [play_cfg_pkg::tick_w-1:0] tick_cnt;
    logic [1:0] count_dn;
    logic [play_cfg_pkg::step_w-1:0] step_cnt;

    // One bit wider than the address so it can reach the chart length
    logic [play_cfg_pkg::addr_w:0] note_idx;
    logic [play_cfg_pkg::addr_w:0] next_idx;

    assign playing = started & ~finished;
    assign judge_stb = playing &&
        (tick_cnt == play_cfg_pkg::tick_w'(play_cfg_pkg::judge_ticks - 1));
    assign note_stb = judge_stb &&
        (step_cnt == play_cfg_pkg::step_w'(play_cfg_pkg::note_judges - 1));
    assign next_idx = note_stb ? note_idx + 1'b1 : note_idx;
    assign note_addr = note_idx[play_cfg_pkg::addr_w-1:0];

    // Countdown 3..0, then one more step before play begins
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            count_dn <= 2'd3;
            started <= 1'b0;
        end else if (!started) begin
            if (tick_cnt == play_cfg_pkg::tick_w'(play_cfg_pkg::count_ticks - 1)) begin
                tick_cnt <= '0;
                if (count_dn == 2'd0) begin
                    started <= 1'b1;
                end else begin
                    count_dn <= count_dn - 2'd1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end else if (playing) begin
            if (judge_stb) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // Note stepping and end of chart
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            note_idx <= '0;
            finished <= 1'b0;
        end else begin
            if (judge_stb) begin
                step_cnt <= note_stb ? '0 : step_cnt + 1'b1;
            end
            note_idx <= next_idx;
            // Empty chart length means the chart never ends
            if ((note_cnt != '0) && (next_idx >= note_cnt)) begin
                finished <= 1'b1;
            end
        end
    end

endmodule

// ==== source/score_judge.sv ====
`timescale 1ns/1ps

module score_judge (
    input logic prog_clk,
    input logic rst,
    input logic judge_stb,
    input logic playing,
    input logic auto_play,
    input logic free_play,
    input play_types_pkg::note_t note_data,
    input play_types_pkg::user_in_t user_in,
    output logic [play_cfg_pkg::score_w-1:0] score,
    output logic [play_cfg_pkg::score_w-1:0] max_score
);

    play_types_pkg::note_t pressed;

    // Last two judged inputs that had a key down
    play_types_pkg::note_t hist_0;
    play_types_pkg::note_t hist_1;

    logic judge_now;

    assign pressed = '{
        oct_down: user_in.oct_down,
        oct_up: user_in.oct_up,
        keys: user_in.note_keys
    };

    // Rests in the chart are not scored
    assign judge_now = judge_stb && playing && !free_play && (note_data.keys != '0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            max_score <= '0;
            hist_0 <= '0;
            hist_1 <= '0;
        end else if (judge_now) begin
            max_score <= max_score + play_cfg_pkg::score_w'(play_cfg_pkg::pts_max);
            if (auto_play) begin
                score <= score + play_cfg_pkg::score_w'(play_cfg_pkg::pts_auto);
            end else if (user_in.note_keys != '0) begin
                hist_0 <= pressed;
                hist_1 <= hist_0;
                // Earlier hits are worth less
                if (pressed == note_data) begin
                    score <= score + play_cfg_pkg::score_w'(play_cfg_pkg::pts_exact);
                end else if (hist_0 == note_data) begin
                    score <= score + play_cfg_pkg::score_w'(play_cfg_pkg::pts_late1);
                end else if (hist_1 == note_data) begin
                    score <= score + play_cfg_pkg::score_w'(play_cfg_pkg::pts_late2);
                end
            end
        end
    end

endmodule

// ==== source/cue_display.sv ====
`timescale 1ns/1ps

module cue_display (
    input logic prog_clk,
    input logic rst,
    input logic started,
    input play_types_pkg::note_t note_data,
    output play_types_pkg::led_t led,
    output play_types_pkg::seg_text_t seg
);

    logic [2:0] degree;
    logic note_ok;
    logic [7:0] letter;
    logic [7:0] oct_ch;
    logic [7:0] digit;
    play_types_pkg::led_t led_next;
    play_types_pkg::seg_text_t seg_next;

    // Position of the pressed key, 0 for C
    always_comb begin
        degree = 3'd0;
        for (int i = 0; i < play_cfg_pkg::key_w; i++) begin
            if (note_data.keys[i]) begin
                degree = 3'(i);
            end
        end
    end

    // Exactly one key, at most one octave flag
    assign note_ok = $onehot(note_data.keys) && !(note_data.oct_up && note_data.oct_down);

    always_comb begin
        case (degree)
            3'd0: letter = "c";
            3'd1: letter = "d";
            3'd2: letter = "e";
            3'd3: letter = "f";
            3'd4: letter = "g";
            3'd5: letter = "a";
            default: letter = "b";
        endcase
    end

    assign oct_ch = note_data.oct_up ? "u" : (note_data.oct_down ? "d" : " ");
    assign digit = "1" + 8'(degree);

    assign seg_next = note_ok ? {letter, " ", oct_ch, " ", digit, "   "} : "        ";

    // LEDs mirror the keys with C on the left
    always_comb begin
        led_next[0] = note_data.oct_up | note_data.oct_down;
        for (int i = 0; i < play_cfg_pkg::key_w; i++) begin
            led_next[7-i] = note_data.keys[i];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= "        ";
        end else if (started) begin
            led <= led_next;
            seg <= seg_next;
        end
    end

endmodule

// ==== source/save_control.sv ====
`timescale 1ns/1ps

module save_control (
    input logic prog_clk,
    input logic rst,
    input logic started,
    input logic free_play,
    input play_types_pkg::user_in_t user_in,
    input logic [play_cfg_pkg::score_w-1:0] score,
    output logic in_menu,
    output logic save_valid,
    output play_types_pkg::save_rec_t save_rec
);

    logic want_exit;
    logic want_save;

    // Arrows only count once the chart has started
    assign want_exit = started && (user_in.arrow == play_cfg_pkg::arrow_left);
    assign want_save = started && (user_in.arrow == play_cfg_pkg::arrow_right);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            in_menu <= 1'b0;
            save_valid <= 1'b0;
        end else begin
            // Exit request sticks until the next reset
            if (want_exit) begin
                in_menu <= 1'b1;
            end
            save_valid <= want_save;
        end
    end

    // Record payload follows the strobe
    always_ff @(posedge prog_clk) begin
        if (want_save) begin
            save_rec <= '{
                user_id: user_in.user_id,
                chart_id: user_in.chart_id,
                score: score,
                free_play: free_play
            };
        end
    end

endmodule

// ==== source/play_chart.sv ====
`timescale 1ns/1ps

module play_chart (
    input logic prog_clk,
    input logic rst,
    input play_types_pkg::user_in_t user_in,
    input logic auto_play,
    input logic free_play,
    input logic [play_cfg_pkg::addr_w:0] note_cnt,
    input play_types_pkg::note_t note_data,
    output logic [play_cfg_pkg::addr_w-1:0] note_addr,
    output play_types_pkg::play_out_t play_out,
    output logic save_valid,
    output play_types_pkg::save_rec_t save_rec
);

    logic started;
    logic finished;
    logic playing;
    logic judge_stb;
    logic note_stb;
    logic in_menu;
    logic [play_cfg_pkg::score_w-1:0] score;
    logic [play_cfg_pkg::score_w-1:0] max_score;
    play_types_pkg::led_t led;
    play_types_pkg::seg_text_t seg;
    play_types_pkg::note_t played;

    play_sequencer u_sequencer (
        .prog_clk (prog_clk),
        .rst (rst),
        .note_cnt (note_cnt),
        .note_addr (note_addr),
        .started (started),
        .finished (finished),
        .playing (playing),
        .judge_stb (judge_stb),
        .note_stb (note_stb)
    );

    score_judge u_judge (
        .prog_clk (prog_clk),
        .rst (rst),
        .judge_stb (judge_stb),
        .playing (playing),
        .auto_play (auto_play),
        .free_play (free_play),
        .note_data (note_data),
        .user_in (user_in),
        .score (score),
        .max_score (max_score)
    );

    cue_display u_cue (
        .prog_clk (prog_clk),
        .rst (rst),
        .started (started),
        .note_data (note_data),
        .led (led),
        .seg (seg)
    );

    save_control u_save (
        .prog_clk (prog_clk),
        .rst (rst),
        .started (started),
        .free_play (free_play),
        .user_in (user_in),
        .score (score),
        .in_menu (in_menu),
        .save_valid (save_valid),
        .save_rec (save_rec)
    );

    // Note heard by the player, taken once per note step
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            played <= '0;
        end else if (note_stb) begin
            if (auto_play) begin
                played <= note_data;
            end else begin
                played <= '{
                    oct_down: user_in.oct_down,
                    oct_up: user_in.oct_up,
                    keys: user_in.note_keys
                };
            end
        end
    end

    assign play_out = '{
        notes: played,
        led: led,
        seg: seg,
        in_menu: in_menu,
        started: started,
        finished: finished
    };

endmodule

// ==== test/play_chart_tests.svh ====
task automatic reset_values();
    int cycles;
    start_test("reset_values");
    note_cnt = 7'd8;
    apply_reset();
    compare("note_addr", 0, note_addr);
    compare("save_valid", 0, save_valid);
    compare("in_menu", 0, play_out.in_menu);
    compare("started", 0, play_out.started);
    compare("finished", 0, play_out.finished);
    compare("led", 0, play_out.led);
    compare("notes", 0, play_out.notes);
    compare("seg", "        ", play_out.seg);
    // Score and maximum live inside the judge
    compare("score", 0, u_play_chart.score);
    compare("max_score", 0, u_play_chart.max_score);
    await_start(cycles);
    compare("start cycle", 4 * play_cfg_pkg::count_ticks, cycles);
    finish_test();
endtask

task automatic note_stepping();
    int cycles;
    int gap;
    int steps;
    bit moved;
    logic [play_cfg_pkg::addr_w-1:0] last;
    start_test("note_stepping");
    load_pattern_chart();
    note_cnt = 7'd9;
    apply_reset();
    await_start(cycles);
    last = note_addr;
    gap = 0;
    steps = 0;
    cycles = 0;
    while (!play_out.finished && cycles < 12 * step_cycles) begin
        @(negedge prog_clk);
        cycles++;
        gap++;
        if (note_addr != last) begin
            compare("step gap", step_cycles, gap);
            compare("next address", last + 1'b1, note_addr);
            compare("finished", note_addr == 6'd9, play_out.finished);
            last = note_addr;
            gap = 0;
            steps++;
        end
    end
    if (!play_out.finished) begin
        note_error("timed out waiting for the chart to finish");
    end
    compare("steps", 9, steps);
    // Address must hold once the chart is over
    moved = 1'b0;
    for (int i = 0; i < 4 * step_cycles; i++) begin
        @(negedge prog_clk);
        if (note_addr != 6'd9) begin
            moved = 1'b1;
        end
    end
    if (moved) begin
        note_error("note address kept moving after the chart finished");
    end
    finish_test();
endtask

task automatic auto_scoring();
    int cycles;
    int n;
    play_types_pkg::save_rec_t rec;
    start_test("auto_scoring");
    n = 12;
    load_random_chart(n);
    note_cnt = 7'(n);
    auto_play = 1'b1;
    free_play = 1'b0;
    apply_reset();
    await_start(cycles);
    play_to_end(0);
    request_save(rec);
    compare("score", n * play_cfg_pkg::note_judges * play_cfg_pkg::pts_auto, rec.score);
    compare("max", n * play_cfg_pkg::note_judges * play_cfg_pkg::pts_max,
            u_play_chart.max_score);
    compare("last played note", chart_mem[n-1], play_out.notes);
    compare("free play flag", 0, rec.free_play);
    free_play = 1'b1;
    apply_reset();
    await_start(cycles);
    play_to_end(0);
    request_save(rec);
    compare("free play score", 0, rec.score);
    compare("free play max", 0, u_play_chart.max_score);
    compare("free play flag", 1, rec.free_play);
    auto_play = 1'b0;
    free_play = 1'b0;
    finish_test();
endtask

task automatic player_scoring();
    int cycles;
    int n;
    play_types_pkg::save_rec_t rec;
    start_test("player_scoring");
    n = 10;
    load_random_chart(n);
    note_cnt = 7'(n);
    apply_reset();
    await_start(cycles);
    play_to_end(1);
    request_save(rec);
    compare("exact score", n * play_cfg_pkg::note_judges * play_cfg_pkg::pts_exact, rec.score);
    compare("max", n * play_cfg_pkg::note_judges * play_cfg_pkg::pts_max,
            u_play_chart.max_score);
    apply_reset();
    await_start(cycles);
    play_to_end(2);
    request_save(rec);
    compare("wrong key score", 0, rec.score);
    compare("wrong key max", n * play_cfg_pkg::note_judges * play_cfg_pkg::pts_max,
            u_play_chart.max_score);
    // All seven keys held, no octave flag
    compare("played keys", 9'h07f, play_out.notes);
    finish_test();
endtask

function automatic play_types_pkg::led_t led_cue(input play_types_pkg::note_t n);
    // C on the top LED, B just above the octave LED
    return {n.keys[0], n.keys[1], n.keys[2], n.keys[3], n.keys[4], n.keys[5], n.keys[6],
            n.oct_up | n.oct_down};
endfunction

function automatic play_types_pkg::seg_text_t seg_cue(input play_types_pkg::note_t n);
    string letters;
    play_types_pkg::seg_text_t s;
    int hits;
    int deg;
    letters = "cdefgab";
    s = "        ";
    hits = 0;
    deg = 0;
    for (int k = 0; k < play_cfg_pkg::key_w; k++) begin
        if (n.keys[k]) begin
            hits++;
            deg = k;
        end
    end
    if (hits == 1 && !(n.oct_up && n.oct_down)) begin
        s[7] = letters[deg];
        s[5] = n.oct_up ? "u" : (n.oct_down ? "d" : " ");
        s[3] = 8'h31 + 8'(deg);
    end
    return s;
endfunction

task automatic cue_decoding();
    int cycles;
    int wait_n;
    start_test("cue_decoding");
    for (int i = 0; i < 21; i++) begin
        chart_mem[i] = make_note(i % 7, i / 7);
    end
    // Two keys and both octave flags
    chart_mem[21] = '{oct_down: 1'b1, oct_up: 1'b1, keys: 7'b0000011};
    note_cnt = 7'd22;
    apply_reset();
    await_start(cycles);
    for (int k = 0; k < 22; k++) begin
        wait_n = 0;
        while (note_addr != 6'(k) && wait_n < 2 * step_cycles) begin
            @(negedge prog_clk);
            wait_n++;
        end
        if (note_addr != 6'(k)) begin
            note_error("timed out waiting for the next chart note");
        end
        // Cue lags the note by one cycle
        @(negedge prog_clk);
        compare($sformatf("led of note %0d", k), led_cue(chart_mem[k]), play_out.led);
        compare($sformatf("seg of note %0d", k), seg_cue(chart_mem[k]), play_out.seg);
    end
    finish_test();
endtask

task automatic save_and_exit();
    int cycles;
    play_types_pkg::save_rec_t exp_rec;
    start_test("save_and_exit");
    load_pattern_chart();
    note_cnt = '0;
    free_play = 1'b1;
    apply_reset();
    user_in.user_id = 8'h5a;
    user_in.chart_id = 8'hc3;
    // Arrows during the countdown
    user_in.arrow = play_cfg_pkg::arrow_right;
    for (int i = 0; i < 8; i++) begin
        @(negedge prog_clk);
        compare("save_valid before start", 0, save_valid);
    end
    user_in.arrow = play_cfg_pkg::arrow_left;
    for (int i = 0; i < 8; i++) begin
        @(negedge prog_clk);
        compare("in_menu before start", 0, play_out.in_menu);
    end
    user_in.arrow = 2'b00;
    await_start(cycles);
    exp_rec = '{user_id: 8'h5a, chart_id: 8'hc3, score: '0, free_play: 1'b1};
    user_in.arrow = play_cfg_pkg::arrow_right;
    for (int i = 0; i < 3; i++) begin
        @(negedge prog_clk);
        compare("save_valid", 1, save_valid);
        compare("save_rec", exp_rec, save_rec);
    end
    user_in.arrow = 2'b00;
    @(negedge prog_clk);
    compare("save_valid after release", 0, save_valid);
    compare("in_menu before left", 0, play_out.in_menu);
    user_in.arrow = play_cfg_pkg::arrow_left;
    @(negedge prog_clk);
    user_in.arrow = 2'b00;
    compare("in_menu", 1, play_out.in_menu);
    @(negedge prog_clk);
    compare("in_menu held", 1, play_out.in_menu);
    free_play = 1'b0;
    finish_test();
endtask

// ==== test/tb_play_chart.sv ====
`timescale 1ns/1ps

module tb_play_chart;

    localparam int start_limit = 4 * play_cfg_pkg::count_ticks + 20;
    localparam int step_cycles = play_cfg_pkg::judge_ticks * play_cfg_pkg::note_judges;

    logic prog_clk;
    logic rst;
    play_types_pkg::user_in_t user_in;
    logic auto_play;
    logic free_play;
    logic [play_cfg_pkg::addr_w:0] note_cnt;
    play_types_pkg::note_t note_data;
    logic [play_cfg_pkg::addr_w-1:0] note_addr;
    play_types_pkg::play_out_t play_out;
    logic save_valid;
    play_types_pkg::save_rec_t save_rec;

    // Chart memory model with a combinational read
    play_types_pkg::note_t chart_mem [0:play_cfg_pkg::chart_len-1];

    string test_name;
    int test_count;
    int check_count;
    int error_count;
    int test_errors;

    assign note_data = chart_mem[note_addr];

    play_chart u_play_chart (
        .prog_clk (prog_clk),
        .rst (rst),
        .user_in (user_in),
        .auto_play (auto_play),
        .free_play (free_play),
        .note_cnt (note_cnt),
        .note_data (note_data),
        .note_addr (note_addr),
        .play_out (play_out),
        .save_valid (save_valid),
        .save_rec (save_rec)
    );

    initial begin
        prog_clk = 1'b0;
        forever begin
            #2 prog_clk = ~prog_clk;
        end
    end

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            test_errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic note_error(input string msg);
        error_count++;
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        $display("%s done, %0d errors", test_name, test_errors);
    endtask

    // Released on a falling edge after 16 cycles
    task automatic apply_reset();
        @(negedge prog_clk);
        rst = 1'b1;
        user_in = '0;
        repeat (16) @(negedge prog_clk);
        rst = 1'b0;
    endtask

    // Cycles counted from reset release
    task automatic await_start(output int cycles);
        cycles = 0;
        while (!play_out.started && cycles < start_limit) begin
            @(negedge prog_clk);
            cycles++;
        end
        if (!play_out.started) begin
            note_error("timed out waiting for the countdown to finish");
        end
    endtask

    // Key modes: 0 none, 1 follow the chart, 2 a chord that never matches
    task automatic play_to_end(input int key_mode);
        int n;
        play_types_pkg::note_t cur;
        n = 0;
        while (!play_out.finished && n < (int'(note_cnt) + 4) * step_cycles) begin
            cur = chart_mem[note_addr];
            if (key_mode == 1) begin
                user_in.note_keys = cur.keys;
                user_in.oct_up = cur.oct_up;
                user_in.oct_down = cur.oct_down;
            end else if (key_mode == 2) begin
                user_in.note_keys = '1;
            end
            @(negedge prog_clk);
            n++;
        end
        user_in.note_keys = '0;
        user_in.oct_up = 1'b0;
        user_in.oct_down = 1'b0;
        if (!play_out.finished) begin
            note_error("timed out waiting for the chart to finish");
        end
    endtask

    task automatic request_save(output play_types_pkg::save_rec_t rec);
        user_in.arrow = play_cfg_pkg::arrow_right;
        @(negedge prog_clk);
        user_in.arrow = 2'b00;
        if (!save_valid) begin
            note_error("no save strobe after a right arrow");
        end
        rec = save_rec;
    endtask

    function automatic play_types_pkg::note_t make_note(input int key, input int oct);
        play_types_pkg::note_t n;
        n = '0;
        n.keys[key] = 1'b1;
        n.oct_up = (oct == 1);
        n.oct_down = (oct == 2);
        return n;
    endfunction

    // Valid note for every address, taken from the full address
    task automatic load_pattern_chart();
        for (int a = 0; a < play_cfg_pkg::chart_len; a++) begin
            chart_mem[a] = make_note(a % 7, (a / 7) % 3);
        end
    endtask

    task automatic load_random_chart(input int count);
        load_pattern_chart();
        for (int a = 0; a < count; a++) begin
            chart_mem[a] = make_note($urandom_range(6, 0), $urandom_range(2, 0));
        end
    endtask

    `include "play_chart_tests.svh"

    initial begin
        void'($urandom(17));
        rst = 1'b1;
        user_in = '0;
        auto_play = 1'b0;
        free_play = 1'b0;
        note_cnt = '0;
        test_count = 0;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        test_name = "setup";
        load_pattern_chart();

        reset_values();
        note_stepping();
        auto_scoring();
        player_scoring();
        cue_decoding();
        save_and_exit();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+test
source/play_cfg_pkg.sv
source/play_types_pkg.sv
source/play_sequencer.sv
source/score_judge.sv
source/cue_display.sv
source/save_control.sv
source/play_chart.sv
test/tb_play_chart.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the play stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tb_play_chart -f files.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_play_chart)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
